// File: rtl/kitchen_pkg.sv
package kitchen_pkg;

   ////////////////////////////////////////
   // game phase codes
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      WELCOME = 3'd0,
      START   = 3'd1,
      PLAY    = 3'd2,
      PAUSE   = 3'd3,
      FINISH  = 3'd4
   } game_phase_t;

   ////////////////////////////////////////
   // shared widths
   ////////////////////////////////////////

   typedef logic [8:0] coord_t;      // one x or y position
   typedef logic [1:0] player_id_t;  // also used for player count minus one
   typedef logic [7:0] seconds_t;    // seconds left in a round
   typedef logic [6:0] segments_t;   // bit 0 is segment a

   // active-high patterns, index is the hex digit
   localparam segments_t HEX_SEGMENTS [16] = '{
      7'h3F, 7'h06, 7'h5B, 7'h4F,
      7'h66, 7'h6D, 7'h7D, 7'h07,
      7'h7F, 7'h6F, 7'h77, 7'h7C,
      7'h39, 7'h5E, 7'h79, 7'h71
   };

endpackage

// File: rtl/button_debounce.sv
`timescale 1ns/1ps

module button_debounce #(
   parameter int SETTLE_CYCLES = 1_000_000
) (
   input  logic clk_in,
   input  logic reset_in,
   input  logic noisy,
   output logic clean
);

   localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

   logic             sample;      // last raw input seen
   logic [CNT_W-1:0] stable_cnt;  // cycles the sample has held

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         sample     <= noisy;
         clean      <= noisy;  // no settle wait out of reset
         stable_cnt <= '0;
      end else if (noisy != sample) begin
         sample     <= noisy;
         stable_cnt <= '0;     // bounce, start over
      end else if (stable_cnt == CNT_W'(SETTLE_CYCLES)) begin
         clean <= sample;
      end else begin
         stable_cnt <= stable_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   // output only ever moves to a value that was held in the sample
   a_clean_from_sample: assert property (
      @(posedge clk_in) disable iff (reset_in)
      (!$past(reset_in) && clean != $past(clean)) |-> clean == $past(sample)
   );

endmodule

// File: rtl/game_phase_fsm.sv
`timescale 1ns/1ps

module game_phase_fsm (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  logic                     chop,
   input  logic                     pause_switch,
   input  logic                     time_up,
   output kitchen_pkg::game_phase_t phase
);

   import kitchen_pkg::*;

   game_phase_t phase_next;
   logic        chop_prev;  // last chop level
   logic        chop_edge;

   assign chop_edge = chop & ~chop_prev;

   ////////////////////////////////////////
   // next phase
   ////////////////////////////////////////

   always_comb begin
      phase_next = phase;
      case (phase)
         WELCOME: begin
            if (chop_edge) phase_next = START;
         end
         START: begin
            if (chop_edge) phase_next = PLAY;
         end
         PLAY: begin
            // running out of time beats a pause request
            if (time_up) begin
               phase_next = FINISH;
            end else if (pause_switch) begin
               phase_next = PAUSE;
            end
         end
         PAUSE: begin
            if (!pause_switch) phase_next = PLAY;
         end
         FINISH: begin
            if (chop_edge) phase_next = WELCOME;  // back for another round
         end
         default: phase_next = WELCOME;
      endcase
   end

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         phase     <= WELCOME;
         chop_prev <= 1'b0;
      end else begin
         phase     <= phase_next;
         chop_prev <= chop;
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   a_phase_legal: assert property (
      @(posedge clk_in) disable iff (reset_in)
      phase inside {WELCOME, START, PLAY, PAUSE, FINISH}
   );

endmodule

// File: rtl/round_timer.sv
`timescale 1ns/1ps

module round_timer #(
   parameter int ROUND_SECONDS    = 120,
   parameter int TICKS_PER_SECOND = 60
) (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  kitchen_pkg::game_phase_t phase,
   input  logic                     frame_tick,
   output kitchen_pkg::seconds_t    time_left,
   output logic                     time_up
);

   import kitchen_pkg::*;

   localparam int TICK_W = $clog2(TICKS_PER_SECOND + 1);

   logic              restart;     // hold at full time
   logic              run;         // counting down
   logic [TICK_W-1:0] tick_count;  // frame ticks into this second

   assign restart = (phase == WELCOME) || (phase == START);
   assign run     = (phase == PLAY);
   assign time_up = (time_left == '0);

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         time_left  <= seconds_t'(ROUND_SECONDS);
         tick_count <= '0;
      end else if (restart) begin
         time_left  <= seconds_t'(ROUND_SECONDS);
         tick_count <= '0;
      end else if (run && frame_tick) begin
         if (tick_count == TICK_W'(TICKS_PER_SECOND - 1)) begin
            tick_count <= '0;
            if (time_left != '0) begin
               time_left <= time_left - 1'b1;  // one second gone
            end
         end else begin
            tick_count <= tick_count + 1'b1;
         end
      end
      // pause and finish just hold
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   a_time_in_range: assert property (
      @(posedge clk_in) disable iff (reset_in)
      time_left <= seconds_t'(ROUND_SECONDS)
   );

endmodule

// File: rtl/opponent_select.sv
`timescale 1ns/1ps

module opponent_select (
   input  logic                    clk_in,
   input  logic                    reset_in,
   input  kitchen_pkg::player_id_t player_id,
   input  kitchen_pkg::player_id_t num_players,
   input  kitchen_pkg::coord_t     player0_x,
   input  kitchen_pkg::coord_t     player0_y,
   input  kitchen_pkg::coord_t     player1_x,
   input  kitchen_pkg::coord_t     player1_y,
   input  kitchen_pkg::coord_t     player2_x,
   input  kitchen_pkg::coord_t     player2_y,
   input  kitchen_pkg::coord_t     player3_x,
   input  kitchen_pkg::coord_t     player3_y,
   output kitchen_pkg::coord_t     opponent_a_x,
   output kitchen_pkg::coord_t     opponent_a_y,
   output kitchen_pkg::coord_t     opponent_b_x,
   output kitchen_pkg::coord_t     opponent_b_y,
   output kitchen_pkg::coord_t     opponent_c_x,
   output kitchen_pkg::coord_t     opponent_c_y
);

   import kitchen_pkg::*;

   coord_t pos_x [4];
   coord_t pos_y [4];
   coord_t sel_x [3];  // slots a, b, c
   coord_t sel_y [3];

   assign pos_x = '{player0_x, player1_x, player2_x, player3_x};
   assign pos_y = '{player0_y, player1_y, player2_y, player3_y};

   // walk ids upward, packing the other active players into the slots
   always_comb begin
      int slot;
      slot = 0;
      for (int s = 0; s < 3; s++) begin
         sel_x[s] = '0;
         sel_y[s] = '0;
      end
      for (int id = 0; id < 4; id++) begin
         if (id <= int'(num_players) && id != int'(player_id) && slot < 3) begin
            sel_x[slot] = pos_x[id];
            sel_y[slot] = pos_y[id];
            slot++;
         end
      end
   end

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         opponent_a_x <= '0;
         opponent_a_y <= '0;
         opponent_b_x <= '0;
         opponent_b_y <= '0;
         opponent_c_x <= '0;
         opponent_c_y <= '0;
      end else begin
         opponent_a_x <= sel_x[0];
         opponent_a_y <= sel_y[0];
         opponent_b_x <= sel_x[1];
         opponent_b_y <= sel_y[1];
         opponent_c_x <= sel_x[2];
         opponent_c_y <= sel_y[2];
      end
   end

endmodule

// File: rtl/status_display.sv
`timescale 1ns/1ps

module status_display #(
   parameter int SCAN_CYCLES = 100_000
) (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  kitchen_pkg::game_phase_t phase,
   input  kitchen_pkg::seconds_t    time_left,
   output kitchen_pkg::segments_t   cathodes,
   output logic [7:0]               anodes
);

   import kitchen_pkg::*;

   localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);

   logic [31:0]       disp_word;   // eight hex digits
   logic [7:0]        digit_sel;   // one-hot, bit 0 is digit 0
   logic [SCAN_W-1:0] scan_count;
   logic [3:0]        nibble;      // value of the lit digit
   segments_t         seg_on;

   ////////////////////////////////////////
   // display contents
   ////////////////////////////////////////

   // digit 7 phase, digits 1..0 time left, the rest zero
   assign disp_word = {1'b0, phase, 20'h0_0000, time_left};

   always_comb begin
      nibble = disp_word[3:0];
      for (int d = 1; d < 8; d++) begin
         if (digit_sel[d]) nibble = disp_word[4*d +: 4];
      end
   end

   assign seg_on   = HEX_SEGMENTS[nibble];
   assign cathodes = ~seg_on;     // active low
   assign anodes   = ~digit_sel;  // active low

   ////////////////////////////////////////
   // digit scan
   ////////////////////////////////////////

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         digit_sel  <= 8'b0000_0001;
         scan_count <= '0;
      end else if (scan_count == SCAN_W'(SCAN_CYCLES)) begin
         scan_count <= '0;
         digit_sel  <= {digit_sel[6:0], digit_sel[7]};  // next digit up
      end else begin
         scan_count <= scan_count + 1'b1;
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   // exactly one digit lit at all times
   a_sel_onehot: assert property (
      @(posedge clk_in) disable iff (reset_in)
      $onehot(digit_sel)
   );

endmodule

// File: rtl/kitchen_station.sv
`timescale 1ns/1ps

module kitchen_station #(
   parameter int SETTLE_CYCLES    = 1_000_000,
   parameter int ROUND_SECONDS    = 120,
   parameter int TICKS_PER_SECOND = 60,
   parameter int SCAN_CYCLES      = 100_000
) (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  logic                     chop_button,
   input  logic                     pause_switch,
   input  logic                     frame_tick,   // once per video frame
   input  kitchen_pkg::player_id_t  player_id,
   input  kitchen_pkg::player_id_t  num_players,  // count minus one
   input  kitchen_pkg::coord_t      player0_x,
   input  kitchen_pkg::coord_t      player0_y,
   input  kitchen_pkg::coord_t      player1_x,
   input  kitchen_pkg::coord_t      player1_y,
   input  kitchen_pkg::coord_t      player2_x,
   input  kitchen_pkg::coord_t      player2_y,
   input  kitchen_pkg::coord_t      player3_x,
   input  kitchen_pkg::coord_t      player3_y,
   output kitchen_pkg::game_phase_t game_phase,
   output kitchen_pkg::seconds_t    time_left,
   output kitchen_pkg::coord_t      opponent_a_x,
   output kitchen_pkg::coord_t      opponent_a_y,
   output kitchen_pkg::coord_t      opponent_b_x,
   output kitchen_pkg::coord_t      opponent_b_y,
   output kitchen_pkg::coord_t      opponent_c_x,
   output kitchen_pkg::coord_t      opponent_c_y,
   output kitchen_pkg::segments_t   cathodes,
   output logic [7:0]               anodes
);

   logic chop_clean;  // settled chop level
   logic time_up;     // round clock at zero

   ////////////////////////////////////////
   // game control
   ////////////////////////////////////////

   button_debounce #(.SETTLE_CYCLES(SETTLE_CYCLES)) i_chop_debounce (
      .clk_in(clk_in), .reset_in(reset_in),
      .noisy(chop_button), .clean(chop_clean)
   );

   game_phase_fsm i_phase_fsm (
      .clk_in(clk_in), .reset_in(reset_in),
      .chop(chop_clean), .pause_switch(pause_switch), .time_up(time_up),
      .phase(game_phase)
   );

   round_timer #(
      .ROUND_SECONDS(ROUND_SECONDS),
      .TICKS_PER_SECOND(TICKS_PER_SECOND)
   ) i_round_timer (
      .clk_in(clk_in), .reset_in(reset_in),
      .phase(game_phase), .frame_tick(frame_tick),
      .time_left(time_left), .time_up(time_up)
   );

   // positions for the collision checks
   opponent_select i_opponent_select (
      .clk_in(clk_in), .reset_in(reset_in),
      .player_id(player_id), .num_players(num_players),
      .player0_x(player0_x), .player0_y(player0_y),
      .player1_x(player1_x), .player1_y(player1_y),
      .player2_x(player2_x), .player2_y(player2_y),
      .player3_x(player3_x), .player3_y(player3_y),
      .opponent_a_x(opponent_a_x), .opponent_a_y(opponent_a_y),
      .opponent_b_x(opponent_b_x), .opponent_b_y(opponent_b_y),
      .opponent_c_x(opponent_c_x), .opponent_c_y(opponent_c_y)
   );

   ////////////////////////////////////////
   // status digits
   ////////////////////////////////////////

   status_display #(.SCAN_CYCLES(SCAN_CYCLES)) i_status_display (
      .clk_in(clk_in), .reset_in(reset_in),
      .phase(game_phase), .time_left(time_left),
      .cathodes(cathodes), .anodes(anodes)
   );

endmodule

// File: test/tb_kitchen_station.sv
`timescale 1ns/1ps

module tb_kitchen_station;

   import kitchen_pkg::*;

   localparam int SETTLE_CYCLES    = 4;
   localparam int ROUND_SECONDS    = 5;
   localparam int TICKS_PER_SECOND = 3;
   localparam int SCAN_CYCLES      = 8;
   localparam int CLK_PERIOD       = 40;
   localparam int SEED             = 59;
   localparam int GLITCH_ROUNDS    = 20;
   localparam int GLITCH_BUDGET    = GLITCH_ROUNDS * (2 * SETTLE_CYCLES + 4);
   localparam int SETTLE_BUDGET    = 6 * SETTLE_CYCLES + 4;  // bounce plus hold
   localparam int COUNTDOWN_CAP    = 300;
   localparam int RUN_CYCLES       = 4 + GLITCH_BUDGET + 6 * SETTLE_BUDGET + COUNTDOWN_CAP + 72;

   logic        clk_in, reset_in, chop_button, pause_switch, frame_tick;
   player_id_t  player_id, num_players;
   coord_t      player_x [4];
   coord_t      player_y [4];
   game_phase_t game_phase;
   seconds_t    time_left;
   coord_t      opp_x [3];
   coord_t      opp_y [3];
   segments_t   cathodes;
   logic [7:0]  anodes;
   logic        rst_drv, chop_drv, pause_drv, tick_drv;  // applied after the next edge

   // model state
   logic        deb_sample, deb_clean, chop_prev;
   int          deb_cnt, m_ticks, m_digit, m_scan;
   game_phase_t m_phase;
   seconds_t    m_time;
   coord_t      m_opp_x [3];
   coord_t      m_opp_y [3];

   kitchen_station #(
      .SETTLE_CYCLES(SETTLE_CYCLES), .ROUND_SECONDS(ROUND_SECONDS),
      .TICKS_PER_SECOND(TICKS_PER_SECOND), .SCAN_CYCLES(SCAN_CYCLES)
   ) i_dut (
      .clk_in(clk_in), .reset_in(reset_in), .chop_button(chop_button),
      .pause_switch(pause_switch), .frame_tick(frame_tick),
      .player_id(player_id), .num_players(num_players),
      .player0_x(player_x[0]), .player0_y(player_y[0]),
      .player1_x(player_x[1]), .player1_y(player_y[1]),
      .player2_x(player_x[2]), .player2_y(player_y[2]),
      .player3_x(player_x[3]), .player3_y(player_y[3]),
      .game_phase(game_phase), .time_left(time_left),
      .opponent_a_x(opp_x[0]), .opponent_a_y(opp_y[0]),
      .opponent_b_x(opp_x[1]), .opponent_b_y(opp_y[1]),
      .opponent_c_x(opp_x[2]), .opponent_c_y(opp_y[2]),
      .cathodes(cathodes), .anodes(anodes)
   );

   initial begin
      clk_in = 1'b0;
      forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
   end

   task automatic abort_run();
      $display("Test FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_phase(string name, game_phase_t got, game_phase_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_time(string name, seconds_t got, seconds_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_coord(string name, coord_t got, coord_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_segments(segments_t got_cath, logic [7:0] got_an,
                                 segments_t exp_cath, logic [7:0] exp_an);
      if ($countones(~got_an) != 1) begin
         $display("anodes do not enable exactly one digit");
         abort_run();
      end
      if (got_an !== exp_an) begin
         $display("ERROR anodes: got %h expected %h", got_an, exp_an);
         abort_run();
      end
      if (got_cath !== exp_cath) begin
         $display("ERROR cathodes: got %h expected %h", got_cath, exp_cath);
         abort_run();
      end
   endtask

   ////////////////////////////////////////
   // cycle model
   ////////////////////////////////////////

   task automatic update_model();
      logic        chop_rise;
      logic        time_up_old;
      game_phase_t phase_old;
      int          opp_ids [$];  // opponents in ascending id order
      chop_rise   = deb_clean & ~chop_prev;  // all from before this edge
      time_up_old = (m_time == '0);
      phase_old   = m_phase;
      if (reset_in) begin
         deb_sample = chop_button;
         deb_clean  = chop_button;
         deb_cnt    = 0;
         chop_prev  = 1'b0;
         m_phase    = WELCOME;
         m_time     = seconds_t'(ROUND_SECONDS);
         m_ticks    = 0;
         m_scan     = 0;
         m_digit    = 0;
      end else begin
         chop_prev = deb_clean;
         if (chop_button != deb_sample) begin
            deb_sample = chop_button;
            deb_cnt    = 0;
         end else if (deb_cnt == SETTLE_CYCLES) begin
            deb_clean = deb_sample;
         end else begin
            deb_cnt++;
         end
         case (phase_old)
            WELCOME: if (chop_rise) m_phase = START;
            START:   if (chop_rise) m_phase = PLAY;
            PLAY: begin
               if (time_up_old) m_phase = FINISH;
               else if (pause_switch) m_phase = PAUSE;
            end
            PAUSE:   if (!pause_switch) m_phase = PLAY;
            FINISH:  if (chop_rise) m_phase = WELCOME;
            default: m_phase = WELCOME;
         endcase
         if (phase_old == WELCOME || phase_old == START) begin
            m_time  = seconds_t'(ROUND_SECONDS);
            m_ticks = 0;
         end else if (phase_old == PLAY && frame_tick) begin
            if (m_ticks == TICKS_PER_SECOND - 1) begin
               m_ticks = 0;
               if (m_time != '0) m_time = m_time - 8'd1;
            end else begin
               m_ticks++;
            end
         end
         if (m_scan == SCAN_CYCLES) begin
            m_scan  = 0;
            m_digit = (m_digit + 1) % 8;
         end else begin
            m_scan++;
         end
      end
      m_opp_x = '{default: '0};
      m_opp_y = '{default: '0};
      if (!reset_in) begin
         // active ids run from 0 up to the count, minus our own
         for (int id = 0; id <= int'(num_players); id++) begin
            if (id != int'(player_id)) opp_ids.push_back(id);
         end
         foreach (opp_ids[i]) begin
            m_opp_x[i] = player_x[opp_ids[i]];
            m_opp_y[i] = player_y[opp_ids[i]];
         end
      end
   endtask

   task automatic check_outputs();
      logic [3:0] nib;
      case (m_digit)
         7:       nib = {1'b0, m_phase};
         1:       nib = m_time[7:4];
         0:       nib = m_time[3:0];
         default: nib = 4'h0;
      endcase
      check_phase("game_phase", game_phase, m_phase);
      check_time("time_left", time_left, m_time);
      check_coord("opponent_a_x", opp_x[0], m_opp_x[0]);
      check_coord("opponent_a_y", opp_y[0], m_opp_y[0]);
      check_coord("opponent_b_x", opp_x[1], m_opp_x[1]);
      check_coord("opponent_b_y", opp_y[1], m_opp_y[1]);
      check_coord("opponent_c_x", opp_x[2], m_opp_x[2]);
      check_coord("opponent_c_y", opp_y[2], m_opp_y[2]);
      check_segments(cathodes, anodes, ~HEX_SEGMENTS[nib], ~(8'd1 << m_digit));
   endtask

   // model at the edge, drive 2 ns later, compare mid cycle
   task automatic next_cycle();
      @(posedge clk_in);
      update_model();
      #2;
      reset_in     = rst_drv;
      chop_button  = chop_drv;
      pause_switch = pause_drv;
      frame_tick   = tick_drv;
      player_id    = player_id_t'($urandom_range(0, 3));
      num_players  = player_id_t'($urandom_range(0, 3));
      for (int p = 0; p < 4; p++) begin
         player_x[p] = coord_t'($urandom);
         player_y[p] = coord_t'($urandom);
      end
      #(CLK_PERIOD / 2 - 2);
      check_outputs();
   endtask

   task automatic run_cycles(int n);
      repeat (n) next_cycle();
   endtask

   // bounce a few short pulses, then hold the level until settled
   task automatic settle_chop(logic level);
      int bounces;
      bounces = $urandom_range(2, 5);
      repeat (bounces) begin
         chop_drv = ~chop_drv;
         run_cycles($urandom_range(1, SETTLE_CYCLES - 1));
      end
      chop_drv = level;
      run_cycles(SETTLE_CYCLES + 4);
   endtask

   task automatic press_chop(game_phase_t expected);
      settle_chop(1'b1);
      settle_chop(1'b0);
      check_phase("game_phase", game_phase, expected);
   endtask

   initial begin
      #((RUN_CYCLES + 50) * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      abort_run();
   end

   initial begin
      int       cyc;
      int       pause_left;
      int       pauses_seen;
      logic     in_pause;
      seconds_t held;
      void'($urandom(SEED));
      reset_in     = 1'b1;
      chop_button  = 1'b0;
      pause_switch = 1'b0;
      frame_tick   = 1'b0;
      player_id    = '0;
      num_players  = '0;
      player_x     = '{default: '0};
      player_y     = '{default: '0};
      rst_drv      = 1'b1;
      chop_drv     = 1'b0;
      pause_drv    = 1'b0;
      tick_drv     = 1'b0;
      run_cycles(3);
      rst_drv = 1'b0;
      next_cycle();  // fourth reset edge

      ////////////////////////////////////////
      // glitches, then real presses
      ////////////////////////////////////////
      repeat (GLITCH_ROUNDS) begin
         chop_drv = 1'b1;
         run_cycles($urandom_range(1, SETTLE_CYCLES - 1));
         chop_drv = 1'b0;
         run_cycles(SETTLE_CYCLES + 4);
         check_phase("game_phase", game_phase, WELCOME);
      end
      press_chop(START);
      press_chop(PLAY);

      // countdown with random ticks and pauses
      cyc         = 0;
      pause_left  = 0;
      pauses_seen = 0;
      in_pause    = 1'b0;
      held        = '0;
      while (m_phase != FINISH && cyc < COUNTDOWN_CAP) begin
         tick_drv = ($urandom_range(0, 1) == 1);
         if (cyc == 6) pause_left = 5;  // at least one pause
         if (pause_left > 0) begin
            pause_drv = 1'b1;
            pause_left--;
         end else begin
            pause_drv = 1'b0;
            if ($urandom_range(0, 15) == 0) pause_left = $urandom_range(3, 8);
         end
         next_cycle();
         cyc++;
         if (m_phase == PAUSE) begin
            if (!in_pause) begin
               held = m_time;
               pauses_seen++;
            end
            in_pause = 1'b1;
            check_time("time_left", time_left, held);
         end else begin
            in_pause = 1'b0;
         end
      end
      if (m_phase != FINISH || pauses_seen == 0) begin
         $display("countdown did not pause and then reach FINISH");
         abort_run();
      end
      pause_drv = 1'b0;
      repeat (10) begin
         tick_drv = ($urandom_range(0, 1) == 1);
         next_cycle();
      end
      check_time("time_left", time_left, seconds_t'(0));
      tick_drv = 1'b0;

      // back to the start screen
      press_chop(WELCOME);
      run_cycles(2);
      check_time("time_left", time_left, seconds_t'(ROUND_SECONDS));
      run_cycles(60);  // more selector and scan coverage

      $display("Test OK");
      $finish;
   end

endmodule

// File: sources.f
rtl/kitchen_pkg.sv
rtl/button_debounce.sv
rtl/game_phase_fsm.sv
rtl/round_timer.sv
rtl/opponent_select.sv
rtl/status_display.sv
rtl/kitchen_station.sv
test/tb_kitchen_station.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_kitchen_station -f sources.f

status=0
output=$(./obj_dir/Vtb_kitchen_station 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "Test OK" <<< "$output"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
